// File: design/dbg_conf_responder.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_conf_responder
   import ncm_pkg::*;
#(
   parameter logic [4:0] EXT_IF_ADDR = 5'h02
) (
   input  wire          clk,
   input  wire          rst,
   input  wire flit16_t req_flit,
   input  wire          req_valid,
   output logic         req_ready,
   output flit16_t      rsp_flit,
   output logic         rsp_valid,
   input  wire          rsp_ready
);

   localparam int IDX_W = (CONF_MEM_SIZE > 1) ? $clog2(CONF_MEM_SIZE) : 1;

   typedef enum logic [1:0] {
      REQ_HDR,
      REQ_BODY,
      RSP_HDR,
      RSP_DATA
   } conf_state_e;

   conf_state_e state;
   dbg_header_t req_hdr;
   dbg_header_t rsp_hdr;
   logic [4:0]  req_src;
   logic [15:0] reg_idx;
   logic [15:0] reg_value;
   logic [15:0] conf_mem [CONF_MEM_SIZE];
   logic        req_fire;
   logic        rsp_fire;

   // Read-only register file
   assign conf_mem[0] = MODULE_TYPE_VERSION;
   assign conf_mem[1] = {11'h000, EXT_IF_ADDR};

   assign reg_value = (reg_idx < 16'(CONF_MEM_SIZE)) ? conf_mem[reg_idx[IDX_W-1:0]] : 16'h0000;

   assign req_hdr = dbg_header_t'(req_flit.data);
   assign rsp_hdr = '{dest: req_src, cls: CLASS_CONF, src: 5'd0, reserved: 3'd0};

   assign req_ready = (state == REQ_HDR) | (state == REQ_BODY);
   assign req_fire  = req_valid & req_ready;
   assign rsp_valid = (state == RSP_HDR) | (state == RSP_DATA);
   assign rsp_fire  = rsp_valid & rsp_ready;

   always_comb begin
      if (state == RSP_DATA) begin
         rsp_flit.ftype = LAST;
         rsp_flit.data  = reg_value;
      end else begin
         rsp_flit.ftype = HEADER;
         rsp_flit.data  = rsp_hdr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= REQ_HDR;
      end else begin
         case (state)
            REQ_HDR: begin
               // Header-only request has no index, ignored
               if (req_fire && req_flit.ftype != SINGLE) state <= REQ_BODY;
            end
            REQ_BODY: if (req_fire && req_flit.ftype == LAST) state <= RSP_HDR;
            RSP_HDR:  if (rsp_fire) state <= RSP_DATA;
            default:  if (rsp_fire) state <= REQ_HDR;
         endcase
      end
   end

   // Requester address and register index
   always_ff @(posedge clk) begin
      if (req_fire && state == REQ_HDR) begin
         req_src <= req_hdr.src;
      end
      if (req_fire && state == REQ_BODY && req_flit.ftype == LAST) begin
         reg_idx <= req_flit.data;
      end
   end

endmodule

`default_nettype wire

// File: design/dbg_port_mux.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_port_mux
   import ncm_pkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire flit16_t dbg_in_flit,
   input  wire          dbg_in_valid,
   output logic         dbg_in_ready,
   output flit16_t      data_in_flit,
   output logic         data_in_valid,
   input  wire          data_in_ready,
   output flit16_t      conf_in_flit,
   output logic         conf_in_valid,
   input  wire          conf_in_ready,
   input  wire flit16_t data_out_flit,
   input  wire          data_out_valid,
   output logic         data_out_ready,
   input  wire flit16_t conf_out_flit,
   input  wire          conf_out_valid,
   output logic         conf_out_ready,
   output flit16_t      dbg_out_flit,
   output logic         dbg_out_valid,
   input  wire          dbg_out_ready
);

   typedef enum logic [1:0] {ROUTE_DATA, ROUTE_CONF, ROUTE_DROP} route_e;
   typedef enum logic [1:0] {GNT_IDLE, GNT_DATA, GNT_CONF} grant_e;

   // Input routing
   dbg_header_t in_hdr;
   route_e      hdr_route;
   route_e      route_q;
   route_e      cur_route;
   logic        in_busy;
   logic        in_fire;
   logic        in_last;

   assign in_hdr = dbg_header_t'(dbg_in_flit.data);

   always_comb begin
      case (in_hdr.cls)
         CLASS_DATA: hdr_route = ROUTE_DATA;
         CLASS_CONF: hdr_route = ROUTE_CONF;
         default:    hdr_route = ROUTE_DROP;
      endcase
   end

   // Header decides, body follows the latched route
   assign cur_route = in_busy ? route_q : hdr_route;

   assign data_in_flit  = dbg_in_flit;
   assign conf_in_flit  = dbg_in_flit;
   assign data_in_valid = dbg_in_valid & (cur_route == ROUTE_DATA);
   assign conf_in_valid = dbg_in_valid & (cur_route == ROUTE_CONF);

   always_comb begin
      case (cur_route)
         ROUTE_DATA: dbg_in_ready = data_in_ready;
         ROUTE_CONF: dbg_in_ready = conf_in_ready;
         default:    dbg_in_ready = 1'b1;
      endcase
   end

   assign in_fire = dbg_in_valid & dbg_in_ready;
   assign in_last = (dbg_in_flit.ftype == LAST) | (dbg_in_flit.ftype == SINGLE);

   always_ff @(posedge clk) begin
      if (rst) begin
         in_busy <= 1'b0;
         route_q <= ROUTE_DROP;
      end else if (in_fire) begin
         if (!in_busy) begin
            route_q <= hdr_route;
         end
         in_busy <= ~in_last;
      end
   end

   // Output arbitration, conf wins at a packet boundary
   grant_e gnt_q;
   grant_e cur_gnt;
   logic   out_fire;
   logic   out_last;

   always_comb begin
      if (gnt_q != GNT_IDLE) begin
         cur_gnt = gnt_q;
      end else if (conf_out_valid) begin
         cur_gnt = GNT_CONF;
      end else if (data_out_valid) begin
         cur_gnt = GNT_DATA;
      end else begin
         cur_gnt = GNT_IDLE;
      end
   end

   assign dbg_out_flit   = (cur_gnt == GNT_CONF) ? conf_out_flit : data_out_flit;
   assign dbg_out_valid  = ((cur_gnt == GNT_CONF) & conf_out_valid) |
                           ((cur_gnt == GNT_DATA) & data_out_valid);
   assign conf_out_ready = (cur_gnt == GNT_CONF) & dbg_out_ready;
   assign data_out_ready = (cur_gnt == GNT_DATA) & dbg_out_ready;

   assign out_fire = dbg_out_valid & dbg_out_ready;
   assign out_last = (dbg_out_flit.ftype == LAST) | (dbg_out_flit.ftype == SINGLE);

   // Lock as soon as a flit is presented, so a stalled flit never changes
   always_ff @(posedge clk) begin
      if (rst) begin
         gnt_q <= GNT_IDLE;
      end else if (dbg_out_valid) begin
         gnt_q <= (out_fire && out_last) ? GNT_IDLE : cur_gnt;
      end
   end

endmodule

`default_nettype wire

// File: design/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_fifo
   import ncm_pkg::*;
#(
   parameter int FIFO_DEPTH = 16
) (
   input  wire          clk,
   input  wire          rst,
   input  wire flit16_t in_flit,
   input  wire          in_valid,
   output logic         in_ready,
   output flit16_t      out_flit,
   output logic         out_valid,
   input  wire          out_ready
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // Storage, no reset needed
   flit16_t mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   // Full once FIFO_DEPTH entries are stored
   assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
   assign out_valid = (count != '0);
   // Show-ahead: head entry straight from the register array
   assign out_flit  = mem[rd_ptr];

   assign wr_en = in_valid & in_ready;
   assign rd_en = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at the depth, which need not be a power of two
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous read and write keeps the count
         if (wr_en && !rd_en) begin
            count <= count + 1'b1;
         end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: design/ncm.sv
`timescale 1ns/1ps
`default_nettype none

module ncm
   import ncm_pkg::*;
#(
   parameter logic [4:0] EXT_IF_ADDR = 5'h02
) (
   input  wire          clk,
   input  wire          rst,
   input  wire          sys_clk_is_halted,
   input  wire flit16_t dbg_in_flit,
   input  wire          dbg_in_valid,
   output logic         dbg_in_ready,
   output flit16_t      dbg_out_flit,
   output logic         dbg_out_valid,
   input  wire          dbg_out_ready,
   input  wire flit32_t noc32_in_flit,
   input  wire          noc32_in_valid,
   output logic         noc32_in_ready,
   output flit32_t      noc32_out_flit,
   output logic         noc32_out_valid,
   input  wire          noc32_out_ready
);

   // Debug data packets toward the packer
   flit16_t d2s_flit, d2s_pk_flit;
   logic    d2s_valid, d2s_ready, d2s_pk_valid, d2s_pk_ready;
   // Config requests and replies
   flit16_t req_flit, rsp_flit;
   logic    req_valid, req_ready, rsp_valid, rsp_ready;
   // System packets toward the debug output
   flit16_t s2d_flit, s2d_mx_flit;
   logic    s2d_valid, s2d_ready, s2d_mx_valid, s2d_mx_ready;

   dbg_port_mux u_mux (
      .clk(clk), .rst(rst),
      .dbg_in_flit(dbg_in_flit), .dbg_in_valid(dbg_in_valid), .dbg_in_ready(dbg_in_ready),
      .data_in_flit(d2s_flit), .data_in_valid(d2s_valid), .data_in_ready(d2s_ready),
      .conf_in_flit(req_flit), .conf_in_valid(req_valid), .conf_in_ready(req_ready),
      .data_out_flit(s2d_mx_flit), .data_out_valid(s2d_mx_valid),
      .data_out_ready(s2d_mx_ready),
      .conf_out_flit(rsp_flit), .conf_out_valid(rsp_valid), .conf_out_ready(rsp_ready),
      .dbg_out_flit(dbg_out_flit), .dbg_out_valid(dbg_out_valid),
      .dbg_out_ready(dbg_out_ready)
   );

   // FIFO A, debug in to packer
   flit_fifo #(.FIFO_DEPTH(16)) u_fifo_d2s (
      .clk(clk), .rst(rst),
      .in_flit(d2s_flit), .in_valid(d2s_valid), .in_ready(d2s_ready),
      .out_flit(d2s_pk_flit), .out_valid(d2s_pk_valid), .out_ready(d2s_pk_ready)
   );

   noc_flit_packer u_packer (
      .clk(clk), .rst(rst), .sys_clk_is_halted(sys_clk_is_halted),
      .in_flit(d2s_pk_flit), .in_valid(d2s_pk_valid), .in_ready(d2s_pk_ready),
      .out_flit(noc32_out_flit), .out_valid(noc32_out_valid), .out_ready(noc32_out_ready)
   );

   noc_flit_splitter u_splitter (
      .clk(clk), .rst(rst), .sys_clk_is_halted(sys_clk_is_halted),
      .in_flit(noc32_in_flit), .in_valid(noc32_in_valid), .in_ready(noc32_in_ready),
      .out_flit(s2d_flit), .out_valid(s2d_valid), .out_ready(s2d_ready)
   );

   // FIFO B, splitter to debug output
   flit_fifo #(.FIFO_DEPTH(32)) u_fifo_s2d (
      .clk(clk), .rst(rst),
      .in_flit(s2d_flit), .in_valid(s2d_valid), .in_ready(s2d_ready),
      .out_flit(s2d_mx_flit), .out_valid(s2d_mx_valid), .out_ready(s2d_mx_ready)
   );

   dbg_conf_responder #(.EXT_IF_ADDR(EXT_IF_ADDR)) u_conf (
      .clk(clk), .rst(rst),
      .req_flit(req_flit), .req_valid(req_valid), .req_ready(req_ready),
      .rsp_flit(rsp_flit), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
   );

endmodule

`default_nettype wire

// File: design/ncm_pkg.sv
`default_nettype none

package ncm_pkg;

   // Flit type codes, same on both networks
   typedef enum logic [1:0] {
      PAYLOAD = 2'b00,
      HEADER  = 2'b01,
      LAST    = 2'b10,
      SINGLE  = 2'b11
   } flit_type_e;

   // Debug network flit, 18 bits
   typedef struct packed {
      flit_type_e  ftype;
      logic [15:0] data;
   } flit16_t;

   // System network flit, 34 bits
   typedef struct packed {
      flit_type_e  ftype;
      logic [31:0] data;
   } flit32_t;

   // Packet class in the debug header
   // Codes other than these two count as unknown
   typedef enum logic [2:0] {
      CLASS_CONF = 3'b000,
      CLASS_DATA = 3'b101
   } pkt_class_e;

   // Debug header word, dest in the top bits
   typedef struct packed {
      logic [4:0] dest;
      pkt_class_e cls;
      logic [4:0] src;
      logic [2:0] reserved;
   } dbg_header_t;

   // Register 0 of the config memory: module type 0x04, version 0x00
   localparam logic [15:0] MODULE_TYPE_VERSION = 16'h0400;

   // Number of config registers
   localparam int CONF_MEM_SIZE = 2;

   // Debug address of the external host
   localparam logic [4:0] DBG_HOST_ADDR = 5'h01;

endpackage

`default_nettype wire

// File: design/noc_flit_packer.sv
`timescale 1ns/1ps
`default_nettype none

module noc_flit_packer
   import ncm_pkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire          sys_clk_is_halted,
   input  wire flit16_t in_flit,
   input  wire          in_valid,
   output logic         in_ready,
   output flit32_t      out_flit,
   output logic         out_valid,
   input  wire          out_ready
);

   logic        expect_hdr;
   logic        have_hi;
   logic        out_first;
   logic        out_held;
   logic [15:0] hi_data;

   logic        in_fire;
   logic        out_fire;
   logic        in_is_last;
   logic        pack_fire;
   logic [31:0] pack_word;
   flit_type_e  pack_type;

   // One held system flit at a time
   assign in_ready = ~out_held;
   assign in_fire  = in_valid & in_ready;

   // System side frozen while the system clock is halted
   assign out_valid = out_held & ~sys_clk_is_halted;
   assign out_fire  = out_valid & out_ready;

   assign in_is_last = (in_flit.ftype == LAST);

   // A word completes on the second half or on an odd last half
   assign pack_fire = in_fire & ~expect_hdr & (have_hi | in_is_last);
   assign pack_word = have_hi ? {hi_data, in_flit.data} : {in_flit.data, 16'h0000};

   always_comb begin
      if (in_is_last) begin
         pack_type = out_first ? SINGLE : LAST;
      end else begin
         pack_type = out_first ? HEADER : PAYLOAD;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         expect_hdr <= 1'b1;
         have_hi    <= 1'b0;
         out_first  <= 1'b0;
         out_held   <= 1'b0;
      end else begin
         if (out_fire) begin
            out_held <= 1'b0;
         end
         if (in_fire) begin
            if (expect_hdr) begin
               // Debug header dropped here
               // A SINGLE header carries no payload
               expect_hdr <= (in_flit.ftype == SINGLE);
               out_first  <= 1'b1;
            end else begin
               have_hi <= ~have_hi & ~in_is_last;
               if (in_is_last) begin
                  expect_hdr <= 1'b1;
               end
            end
         end
         if (pack_fire) begin
            out_held  <= 1'b1;
            out_first <= 1'b0;
         end
      end
   end

   // Payload path
   always_ff @(posedge clk) begin
      if (in_fire && !expect_hdr && !have_hi) begin
         hi_data <= in_flit.data;
      end
      if (pack_fire) begin
         out_flit.ftype <= pack_type;
         out_flit.data  <= pack_word;
      end
   end

endmodule

`default_nettype wire

// File: design/noc_flit_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module noc_flit_splitter
   import ncm_pkg::*;
(
   input  wire          clk,
   input  wire          rst,
   input  wire          sys_clk_is_halted,
   input  wire flit32_t in_flit,
   input  wire          in_valid,
   output logic         in_ready,
   output flit16_t      out_flit,
   output logic         out_valid,
   input  wire          out_ready
);

   typedef enum logic [1:0] {
      IDLE,
      SEND_HDR,
      SEND_HI,
      SEND_LO
   } split_state_e;

   split_state_e state;
   flit32_t      sys_buf;
   dbg_header_t  gen_hdr;
   logic         in_fire;
   logic         out_fire;
   logic         sys_is_first;
   logic         sys_is_last;

   // Generated header toward the host
   assign gen_hdr = '{dest: DBG_HOST_ADDR, cls: CLASS_DATA, src: 5'd0, reserved: 3'd0};

   // New system flit only when idle and the system clock runs
   assign in_ready = (state == IDLE) & ~sys_clk_is_halted;
   assign in_fire  = in_valid & in_ready;
   assign out_valid = (state != IDLE);
   assign out_fire  = out_valid & out_ready;

   assign sys_is_first = (in_flit.ftype == HEADER) | (in_flit.ftype == SINGLE);
   assign sys_is_last  = (sys_buf.ftype == LAST) | (sys_buf.ftype == SINGLE);

   always_comb begin
      case (state)
         SEND_HDR: begin
            out_flit.ftype = HEADER;
            out_flit.data  = gen_hdr;
         end
         SEND_HI: begin
            out_flit.ftype = PAYLOAD;
            out_flit.data  = sys_buf.data[31:16];
         end
         default: begin
            // Lower half closes the packet after a SINGLE or LAST flit
            out_flit.ftype = sys_is_last ? LAST : PAYLOAD;
            out_flit.data  = sys_buf.data[15:0];
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (in_fire) begin
                  state <= sys_is_first ? SEND_HDR : SEND_HI;
               end
            end
            SEND_HDR: if (out_fire) state <= SEND_HI;
            SEND_HI:  if (out_fire) state <= SEND_LO;
            default:  if (out_fire) state <= IDLE;
         endcase
      end
   end

   // Latched system flit
   always_ff @(posedge clk) begin
      if (in_fire) begin
         sys_buf <= in_flit;
      end
   end

endmodule

`default_nettype wire

// File: ncm.f
design/ncm_pkg.sv
design/flit_fifo.sv
design/noc_flit_packer.sv
design/noc_flit_splitter.sv
design/dbg_conf_responder.sv
design/dbg_port_mux.sv
design/ncm.sv
verif/tb_clock_gen.sv
verif/ncm_checker.sv
verif/ncm_tb.sv

// File: verif/ncm_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ncm_checker
   import ncm_pkg::*;
(
   input wire          clk,
   input wire          rst,
   input wire          sys_clk_is_halted,
   input wire flit16_t dbg_out_flit,
   input wire          dbg_out_valid,
   input wire          dbg_out_ready,
   input wire          noc32_in_ready,
   input wire flit32_t noc32_out_flit,
   input wire          noc32_out_valid,
   input wire          noc32_out_ready
);

   // Failed assertions so far
   int fail_count = 0;

   // Outputs quiet once a reset edge has been seen
   a_reset_quiet: assert property (@(posedge clk)
      rst |=> !dbg_out_valid && !noc32_out_valid)
      else begin
         fail_count++;
         $error("output valid high after a reset cycle");
      end

   // Stalled debug flit held until taken
   a_dbg_stable: assert property (@(posedge clk) disable iff (rst)
      dbg_out_valid && !dbg_out_ready |=> dbg_out_valid && $stable(dbg_out_flit))
      else begin
         fail_count++;
         $error("dbg_out flit changed or dropped under back-pressure");
      end

   // Stalled system flit held, valid may only drop for a halt
   a_sys_stable: assert property (@(posedge clk) disable iff (rst)
      noc32_out_valid && !noc32_out_ready |=>
         $stable(noc32_out_flit) && (noc32_out_valid || sys_clk_is_halted))
      else begin
         fail_count++;
         $error("noc32_out flit changed or dropped under back-pressure");
      end

   // System side frozen during a halt
   a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
      sys_clk_is_halted |-> !noc32_out_valid && !noc32_in_ready)
      else begin
         fail_count++;
         $error("system handshake active while halted");
      end

endmodule

bind ncm ncm_checker u_checker (
   .clk(clk),
   .rst(rst),
   .sys_clk_is_halted(sys_clk_is_halted),
   .dbg_out_flit(dbg_out_flit),
   .dbg_out_valid(dbg_out_valid),
   .dbg_out_ready(dbg_out_ready),
   .noc32_in_ready(noc32_in_ready),
   .noc32_out_flit(noc32_out_flit),
   .noc32_out_valid(noc32_out_valid),
   .noc32_out_ready(noc32_out_ready)
);

`default_nettype wire

// File: verif/ncm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ncm_tb
   import ncm_pkg::*;
();

   localparam logic [4:0] EXT_IF_ADDR = 5'h0a;
   localparam int MAX_WORDS       = 256;
   localparam int DRAIN_CYCLES    = 16;
   localparam int CYCLES_PER_FLIT = 20;

   logic    clk;
   logic    rst;
   logic    sys_clk_is_halted;
   flit16_t dbg_in_flit;
   logic    dbg_in_valid;
   logic    dbg_in_ready;
   flit16_t dbg_out_flit;
   logic    dbg_out_valid;
   logic    dbg_out_ready;
   flit32_t noc32_in_flit;
   logic    noc32_in_valid;
   logic    noc32_in_ready;
   flit32_t noc32_out_flit;
   logic    noc32_out_valid;
   logic    noc32_out_ready;

   // Test words as read, then split per port for the running test
   logic [43:0] tv [MAX_WORDS];
   logic [43:0] dbg_in_q [$];
   logic [43:0] sys_in_q [$];
   logic [33:0] dbg_exp_q [$];
   logic [33:0] sys_exp_q [$];

   integer seed;
   logic   random_ready;
   int     errors;
   int     n_tests;
   int     total_flits;
   int     cycle_count;
   int     cycle_limit;

   tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(2)) u_clk_gen (.clk(clk), .rst(rst));

   ncm #(.EXT_IF_ADDR(EXT_IF_ADDR)) u_dut (
      .clk(clk), .rst(rst), .sys_clk_is_halted(sys_clk_is_halted),
      .dbg_in_flit(dbg_in_flit), .dbg_in_valid(dbg_in_valid), .dbg_in_ready(dbg_in_ready),
      .dbg_out_flit(dbg_out_flit), .dbg_out_valid(dbg_out_valid),
      .dbg_out_ready(dbg_out_ready),
      .noc32_in_flit(noc32_in_flit), .noc32_in_valid(noc32_in_valid),
      .noc32_in_ready(noc32_in_ready),
      .noc32_out_flit(noc32_out_flit), .noc32_out_valid(noc32_out_valid),
      .noc32_out_ready(noc32_out_ready)
   );

   function automatic int total_errors();
      return errors + u_dut.u_checker.fail_count;
   endfunction

   // Count tests and flits up to the zero end word
   task automatic scan_tests();
      int ptr;
      ptr = 0;
      n_tests = 0;
      total_flits = 0;
      while (ptr < MAX_WORDS && !$isunknown(tv[ptr]) && tv[ptr][43:40] != 4'h0) begin
         n_tests++;
         total_flits += tv[ptr][15:8] + tv[ptr][7:0];
         ptr += 1 + tv[ptr][15:8] + tv[ptr][7:0];
      end
   endtask

   // Debug input, idle gap first if the word asks for one
   task automatic drive_dbg_in();
      logic [43:0] w;
      while (dbg_in_q.size() > 0) begin
         w = dbg_in_q.pop_front();
         if (w[39:36] != 4'h0) begin
            dbg_in_valid = 1'b0;
            repeat (w[39:36]) @(negedge clk);
         end
         dbg_in_flit  = w[17:0];
         dbg_in_valid = 1'b1;
         do begin
            @(posedge clk);
         end while (!dbg_in_ready);
         @(negedge clk);
      end
      dbg_in_valid = 1'b0;
   endtask

   task automatic drive_sys_in();
      logic [43:0] w;
      while (sys_in_q.size() > 0) begin
         w = sys_in_q.pop_front();
         if (w[39:36] != 4'h0) begin
            noc32_in_valid = 1'b0;
            repeat (w[39:36]) @(negedge clk);
         end
         noc32_in_flit  = w[33:0];
         noc32_in_valid = 1'b1;
         do begin
            @(posedge clk);
         end while (!noc32_in_ready);
         @(negedge clk);
      end
      noc32_in_valid = 1'b0;
   endtask

   task automatic drive_halt(input int start, input int len);
      if (len > 0) begin
         repeat (start) @(negedge clk);
         sys_clk_is_halted = 1'b1;
         repeat (len) @(negedge clk);
         sys_clk_is_halted = 1'b0;
      end
   endtask

   // Ready for both outputs, random only in tests that ask for it
   always @(negedge clk) begin : ready_drive
      logic [31:0] rnd;
      if (random_ready) begin
         rnd = $random(seed);
         dbg_out_ready   = rnd[0];
         noc32_out_ready = rnd[5];
      end else begin
         dbg_out_ready   = 1'b1;
         noc32_out_ready = 1'b1;
      end
   end

   // In-order scoreboard on both outputs
   always @(posedge clk) begin : out_monitor
      logic [33:0] exp;
      if (!rst) begin
         if (dbg_out_valid && dbg_out_ready) begin
            if (dbg_exp_q.size() == 0) begin
               $display("unexpected flit on dbg_out: 0x%05h", dbg_out_flit);
               errors++;
            end else begin
               exp = dbg_exp_q.pop_front();
               if (dbg_out_flit !== exp[17:0]) begin
                  $display("error dbg_out_flit got 0x%05h expected 0x%05h",
                           dbg_out_flit, exp[17:0]);
                  errors++;
               end
            end
         end
         if (noc32_out_valid && noc32_out_ready) begin
            if (sys_exp_q.size() == 0) begin
               $display("unexpected flit on noc32_out: 0x%09h", noc32_out_flit);
               errors++;
            end else begin
               exp = sys_exp_q.pop_front();
               if (noc32_out_flit !== exp) begin
                  $display("error noc32_out_flit got 0x%09h expected 0x%09h",
                           noc32_out_flit, exp);
                  errors++;
               end
            end
         end
         if (sys_clk_is_halted && ((noc32_in_valid && noc32_in_ready) ||
                                   (noc32_out_valid && noc32_out_ready))) begin
            $display("a system flit was transferred while the system clock was halted");
            errors++;
         end
      end
   end

   always @(posedge clk) begin : watchdog
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("timeout: tests not finished after %0d cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin : main
      int          ptr;
      int          kind;
      int          n_in;
      int          n_exp;
      int          err_start;
      int          n_failed;
      logic [43:0] w;
      sys_clk_is_halted = 1'b0;
      dbg_in_flit       = '0;
      dbg_in_valid      = 1'b0;
      noc32_in_flit     = '0;
      noc32_in_valid    = 1'b0;
      dbg_out_ready     = 1'b1;
      noc32_out_ready   = 1'b1;
      random_ready      = 1'b0;
      seed              = 32'h308b_4c67;
      errors            = 0;
      n_failed          = 0;
      cycle_count       = 0;
      cycle_limit       = 0;
      $readmemh("verif/ncm_tests.txt", tv);
      scan_tests();
      cycle_limit = total_flits * CYCLES_PER_FLIT + n_tests * DRAIN_CYCLES;
      wait (rst == 1'b0);
      @(negedge clk);
      if (n_tests == 0) begin
         $display("no tests could be read from verif/ncm_tests.txt");
         errors++;
      end else begin
         ptr = 0;
         for (int t = 1; t <= n_tests; t++) begin
            w = tv[ptr];
            kind = w[43:40];
            n_in = w[15:8];
            n_exp = w[7:0];
            ptr++;
            // Port nibble picks the queue
            for (int i = 0; i < n_in; i++) begin
               if (tv[ptr][43:40] == 4'h1) sys_in_q.push_back(tv[ptr]);
               else dbg_in_q.push_back(tv[ptr]);
               ptr++;
            end
            for (int i = 0; i < n_exp; i++) begin
               if (tv[ptr][43:40] == 4'h1) sys_exp_q.push_back(tv[ptr][33:0]);
               else dbg_exp_q.push_back(tv[ptr][33:0]);
               ptr++;
            end
            err_start = total_errors();
            // Ready mode changes away from the falling edge
            @(posedge clk);
            random_ready = w[36];
            @(negedge clk);
            fork
               drive_dbg_in();
               drive_sys_in();
               drive_halt(w[31:24], w[23:16]);
            join
            while (dbg_exp_q.size() > 0 || sys_exp_q.size() > 0) @(negedge clk);
            // Quiet window to catch stray flits
            repeat (DRAIN_CYCLES) @(negedge clk);
            @(posedge clk);
            random_ready = 1'b0;
            @(negedge clk);
            if (total_errors() > err_start) begin
               n_failed++;
               $display("test %0d kind %0d failed", t, kind);
            end else begin
               $display("test %0d kind %0d ok", t, kind);
            end
         end
      end
      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
      if (total_errors() == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/ncm_tests.txt
// header: kind, random ready, 0, halt start (2), halt length (2), inputs (2), expected (2)
// input: port (0 dbg_in, 1 noc32_in), idle cycles before, flit; expected: port, 0, flit
// 1: debug data packets with odd, single and even payload
10000000B05
00000011518 00000001111 00000002222 00000003333 00000004444 00000025555
00000011518 0000002AAAA
00000011518 0000000BBBB 0000002CCCC
10111112222 10033334444 10255550000 103AAAA0000 103BBBBCCCC
// 2: system packets, three flits and a SINGLE
2000000040A
101DEADBEEF 10001234567 10289ABCDEF 103CAFEF00D
00000010D00 0000000DEAD 0000000BEEF 00000000123 00000004567
000000089AB 0000002CDEF 00000010D00 0000000CAFE 0000002F00D
// 3: config reads of index 0, 1 and 5
30000000606
00000011038 00000020000 00000011048 00000020001 000000110F8 00000020005
00000013800 00000020400 00000014800 0000002000A 0000001F800 00000020000
// 4: random ready on both outputs
41000000707
00000011518 0000000A1B2 0000000C3D4 0000000E5F6 00000027788
10111223344 10255667788
101A1B2C3D4 102E5F67788
00000010D00 00000001122 00000003344 00000005566 00000027788
// 5: halt from cycle 2 for 12 cycles
500020C0707
00000011518 00000001357 0000000248A 00000009BDF 00000020246
1210F0E0D0C 1020B0A0908
1011357248A 1029BDF0246
00000010D00 00000000F0E 00000000D0C 00000000B0A 00000020908
// 6: long system packet, unknown class packet, config read during the stream
6000000090B
10110002000 10030004000 10050006000 10270008000
00000011218 00000007777 00000028888
02000011038 00000020001
00000010D00 00000001000 00000002000 00000003000 00000004000 00000005000
00000006000 00000007000 00000028000 00000013800 0000002000A
// end of tests
00000000000

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset seen on RESET_CYCLES rising edges, dropped on a falling edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire
